//--- rtl/ccu_settings.svh
// **************************************************
// CCU settings
// Address, line and queue sizes plus memory latency
// shared by every block of the cache control unit
// **************************************************

`ifndef CCU_SETTINGS_SVH
`define CCU_SETTINGS_SVH

// Byte address and cacheline geometry
`define CCU_ADDR_WIDTH      16
`define CCU_LINE_BYTES      8
`define CCU_LINE_WIDTH      (`CCU_LINE_BYTES * 8)
`define CCU_OFFSET_WIDTH    3

// Backing memory size, index is log2 of the line count
`define CCU_MEM_LINES       64
`define CCU_MEM_IDX_WIDTH   6

// Queue depths double as the requester's starting credits
`define CCU_IFQ_DEPTH       2
`define CCU_IFQ_PTR_WIDTH   1
`define CCU_WBQ_DEPTH       2
`define CCU_WBQ_PTR_WIDTH   1

// Cycles from accepted request to completion pulse
`define CCU_MEM_LATENCY     3
`define CCU_MEM_CNT_WIDTH   2

`endif

//--- rtl/ccu_pkg.sv
// **************************************************
// CCU package
// Memory opcode and arbiter state types
// **************************************************

package ccu_pkg;

    // Memory transaction type
    typedef enum logic {
        CCU_OP_READ  = 1'b0,
        CCU_OP_WRITE = 1'b1
    } ccu_op_e;

    // Arbiter owns the memory for one transaction at a time
    typedef enum logic {
        ARB_IDLE = 1'b0,
        ARB_BUSY = 1'b1
    } arb_state_e;

endpackage

//--- rtl/ccu_ifq.sv
// **************************************************
// Instruction fetch queue
// Holds icache miss addresses, requests line reads
// in order and returns each line as a fill together
// with a credit pulse
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_ifq (
    input  logic                            clk,
    input  logic                            i_arst_n,

    // Miss allocation from the icache
    input  logic                            i_ifq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_ifq_alloc_addr,

    // Fill and credit back to the icache
    output logic                            o_ifq_fill_en,
    output logic [`CCU_ADDR_WIDTH-1:0]      o_ifq_fill_addr,
    output logic [`CCU_LINE_WIDTH-1:0]      o_ifq_fill_data,
    output logic                            o_ifq_credit,

    // Arbiter side
    output logic                            o_req,
    output logic [`CCU_ADDR_WIDTH-1:0]      o_req_addr,
    input  logic                            i_done,
    input  logic [`CCU_LINE_WIDTH-1:0]      i_rdata
);

    logic [`CCU_IFQ_DEPTH-1:0]                      entry_valid;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]     entry_addr [`CCU_IFQ_DEPTH];
    logic [`CCU_IFQ_PTR_WIDTH-1:0]                  head_q;
    logic [`CCU_IFQ_PTR_WIDTH-1:0]                  tail_q;
    logic [`CCU_ADDR_WIDTH-1:0]                     head_addr;
    logic                                           fill_en_q;

    // Line aligned address of the oldest entry
    assign head_addr = {entry_addr[head_q], {`CCU_OFFSET_WIDTH{1'b0}}};

    // Valid bits and pointers, depth is a power of two so pointers wrap on their own
    // The requester only allocates with a credit, so tail never runs into a valid head
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            entry_valid <= '0;
            head_q      <= '0;
            tail_q      <= '0;
        end else begin
            if (i_ifq_alloc_en) begin
                entry_valid[tail_q] <= 1'b1;
                tail_q              <= tail_q + 1'b1;
            end
            if (i_done) begin
                entry_valid[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
        end
    end

    // Only the line address is kept
    always_ff @(posedge clk) begin
        if (i_ifq_alloc_en) begin
            entry_addr[tail_q] <= i_ifq_alloc_addr[`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH];
        end
    end

    // Fill pulse one cycle after done
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fill_en_q <= 1'b0;
        end else begin
            fill_en_q <= i_done;
        end
    end

    // Capture address and read data while the head is still current
    always_ff @(posedge clk) begin
        if (i_done) begin
            o_ifq_fill_addr <= head_addr;
            o_ifq_fill_data <= i_rdata;
        end
    end

    assign o_ifq_fill_en = fill_en_q;
    // Entry is freed on the same edge, so the credit goes out with the fill
    assign o_ifq_credit  = fill_en_q;

    // Head entry is presented as a read request
    assign o_req      = entry_valid[head_q];
    assign o_req_addr = head_addr;

endmodule

//--- rtl/ccu_wbq.sv
// **************************************************
// Write-back queue
// Stores dirty lines with their addresses, writes
// them to memory in order and returns a credit
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_wbq (
    input  logic                            clk,
    input  logic                            i_arst_n,

    // Dirty line allocation
    input  logic                            i_wbq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_wbq_alloc_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]      i_wbq_alloc_data,
    output logic                            o_wbq_credit,

    // Arbiter side
    output logic                            o_req,
    output logic [`CCU_ADDR_WIDTH-1:0]      o_req_addr,
    output logic [`CCU_LINE_WIDTH-1:0]      o_req_data,
    input  logic                            i_done
);

    logic [`CCU_WBQ_DEPTH-1:0]                      entry_valid;
    logic [`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH]     entry_addr [`CCU_WBQ_DEPTH];
    logic [`CCU_LINE_WIDTH-1:0]                     entry_data [`CCU_WBQ_DEPTH];
    logic [`CCU_WBQ_PTR_WIDTH-1:0]                  head_q;
    logic [`CCU_WBQ_PTR_WIDTH-1:0]                  tail_q;
    logic                                           credit_q;

    // Valid bits and wrapping pointers
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            entry_valid <= '0;
            head_q      <= '0;
            tail_q      <= '0;
        end else begin
            if (i_wbq_alloc_en) begin
                entry_valid[tail_q] <= 1'b1;
                tail_q              <= tail_q + 1'b1;
            end
            if (i_done) begin
                entry_valid[head_q] <= 1'b0;
                head_q              <= head_q + 1'b1;
            end
        end
    end

    // Address and line payload
    always_ff @(posedge clk) begin
        if (i_wbq_alloc_en) begin
            entry_addr[tail_q] <= i_wbq_alloc_addr[`CCU_ADDR_WIDTH-1:`CCU_OFFSET_WIDTH];
            entry_data[tail_q] <= i_wbq_alloc_data;
        end
    end

    // Credit goes back once the write has landed in memory
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            credit_q <= 1'b0;
        end else begin
            credit_q <= i_done;
        end
    end

    assign o_wbq_credit = credit_q;

    // Oldest entry is the pending write
    assign o_req      = entry_valid[head_q];
    assign o_req_addr = {entry_addr[head_q], {`CCU_OFFSET_WIDTH{1'b0}}};
    assign o_req_data = entry_data[head_q];

endmodule

//--- rtl/ccu_arbiter.sv
// **************************************************
// Memory arbiter
// Round-robin grant between IFQ and WBQ, one memory
// transaction at a time, done routed to the owner
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_arbiter (
    input  logic                            clk,
    input  logic                            i_arst_n,

    // IFQ read requests
    input  logic                            i_ifq_req,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_ifq_addr,
    output logic                            o_ifq_done,

    // WBQ write requests
    input  logic                            i_wbq_req,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_wbq_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]      i_wbq_data,
    output logic                            o_wbq_done,

    // Memory side
    output logic                            o_mem_en,
    output ccu_pkg::ccu_op_e                o_mem_op,
    output logic [`CCU_ADDR_WIDTH-1:0]      o_mem_addr,
    output logic [`CCU_LINE_WIDTH-1:0]      o_mem_wdata,
    input  logic                            i_mem_done
);

    ccu_pkg::arb_state_e    state_q;
    ccu_pkg::arb_state_e    state_d;
    logic                   turn_q;     // WBQ has priority when set
    logic                   owner_q;    // WBQ holds the grant when set
    logic                   idle;
    logic                   mem_start;
    logic                   mem_finish;
    logic                   grant_wbq;
    logic                   sel_wbq;

    assign idle       = (state_q == ccu_pkg::ARB_IDLE);
    assign mem_start  = idle & (i_ifq_req | i_wbq_req);
    assign mem_finish = ~idle & i_mem_done;

    // Lone requester wins, otherwise the turn bit decides
    assign grant_wbq = i_wbq_req & (~i_ifq_req | turn_q);

    // Owner register is not loaded yet in the grant cycle
    assign sel_wbq = idle ? grant_wbq : owner_q;

    assign o_mem_en    = mem_start;
    assign o_mem_op    = sel_wbq ? ccu_pkg::CCU_OP_WRITE : ccu_pkg::CCU_OP_READ;
    assign o_mem_addr  = sel_wbq ? i_wbq_addr : i_ifq_addr;
    assign o_mem_wdata = sel_wbq ? i_wbq_data : '0;

    // Completion goes only to the queue that owns the transaction
    assign o_ifq_done = mem_finish & ~owner_q;
    assign o_wbq_done = mem_finish & owner_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::ARB_IDLE: begin
                if (mem_start) begin
                    state_d = ccu_pkg::ARB_BUSY;
                end
            end
            ccu_pkg::ARB_BUSY: begin
                if (i_mem_done) begin
                    state_d = ccu_pkg::ARB_IDLE;
                end
            end
            default: state_d = ccu_pkg::ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_q <= ccu_pkg::ARB_IDLE;
            turn_q  <= 1'b0;
            owner_q <= 1'b0;
        end else begin
            state_q <= state_d;
            if (mem_start) begin
                owner_q <= grant_wbq;
            end
            // Next turn belongs to the queue just served's peer
            if (mem_finish) begin
                turn_q <= ~owner_q;
            end
        end
    end

endmodule

//--- rtl/ccu_mem.sv
// **************************************************
// Backing memory
// Line-wide array with fixed access latency and a
// one-cycle completion pulse
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_mem (
    input  logic                            clk,
    input  logic                            i_arst_n,
    input  logic                            i_mem_en,
    input  ccu_pkg::ccu_op_e                i_mem_op,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_mem_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]      i_mem_wdata,
    output logic                            o_mem_done,
    output logic [`CCU_LINE_WIDTH-1:0]      o_mem_rdata
);

    logic [`CCU_LINE_WIDTH-1:0]     mem_array [`CCU_MEM_LINES];
    logic                           busy_q;
    logic [`CCU_MEM_CNT_WIDTH-1:0]  cnt_q;
    ccu_pkg::ccu_op_e               op_q;
    logic [`CCU_MEM_IDX_WIDTH-1:0]  idx_q;
    logic [`CCU_LINE_WIDTH-1:0]     wdata_q;
    logic                           accept;

    assign accept = i_mem_en & ~busy_q;

    // Done when the countdown reaches zero, latency cycles after accept
    assign o_mem_done  = busy_q & (cnt_q == '0);
    assign o_mem_rdata = mem_array[idx_q];

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_q <= 1'b0;
            cnt_q  <= '0;
        end else if (accept) begin
            busy_q <= 1'b1;
            cnt_q  <= (`CCU_MEM_CNT_WIDTH)'(`CCU_MEM_LATENCY - 1);
        end else if (o_mem_done) begin
            busy_q <= 1'b0;
        end else if (busy_q) begin
            cnt_q <= cnt_q - 1'b1;
        end
    end

    // Request latch, line index sits just above the offset
    always_ff @(posedge clk) begin
        if (accept) begin
            op_q    <= i_mem_op;
            idx_q   <= i_mem_addr[`CCU_OFFSET_WIDTH+`CCU_MEM_IDX_WIDTH-1:`CCU_OFFSET_WIDTH];
            wdata_q <= i_mem_wdata;
        end
    end

    // Writes land on the done cycle
    always_ff @(posedge clk) begin
        if (o_mem_done && (op_q == ccu_pkg::CCU_OP_WRITE)) begin
            mem_array[idx_q] <= wdata_q;
        end
    end

endmodule

//--- rtl/ccu_top.sv
// **************************************************
// Cache control unit top level
// IFQ and WBQ sharing one backing memory through
// a round-robin arbiter
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_top (
    input  logic                            clk,
    input  logic                            i_arst_n,

    // Instruction fetch requester
    input  logic                            i_ifq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_ifq_alloc_addr,
    output logic                            o_ifq_fill_en,
    output logic [`CCU_ADDR_WIDTH-1:0]      o_ifq_fill_addr,
    output logic [`CCU_LINE_WIDTH-1:0]      o_ifq_fill_data,
    output logic                            o_ifq_credit,

    // Write-back requester
    input  logic                            i_wbq_alloc_en,
    input  logic [`CCU_ADDR_WIDTH-1:0]      i_wbq_alloc_addr,
    input  logic [`CCU_LINE_WIDTH-1:0]      i_wbq_alloc_data,
    output logic                            o_wbq_credit
);

    logic                           ifq_req;
    logic [`CCU_ADDR_WIDTH-1:0]     ifq_req_addr;
    logic                           ifq_done;
    logic                           wbq_req;
    logic [`CCU_ADDR_WIDTH-1:0]     wbq_req_addr;
    logic [`CCU_LINE_WIDTH-1:0]     wbq_req_data;
    logic                           wbq_done;
    logic                           mem_en;
    ccu_pkg::ccu_op_e               mem_op;
    logic [`CCU_ADDR_WIDTH-1:0]     mem_addr;
    logic [`CCU_LINE_WIDTH-1:0]     mem_wdata;
    logic                           mem_done;
    logic [`CCU_LINE_WIDTH-1:0]     mem_rdata;

    ccu_ifq u_ifq (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_ifq_alloc_en(i_ifq_alloc_en), .i_ifq_alloc_addr(i_ifq_alloc_addr),
        .o_ifq_fill_en(o_ifq_fill_en), .o_ifq_fill_addr(o_ifq_fill_addr),
        .o_ifq_fill_data(o_ifq_fill_data), .o_ifq_credit(o_ifq_credit),
        .o_req(ifq_req), .o_req_addr(ifq_req_addr),
        .i_done(ifq_done), .i_rdata(mem_rdata)
    );

    ccu_wbq u_wbq (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_wbq_alloc_en(i_wbq_alloc_en), .i_wbq_alloc_addr(i_wbq_alloc_addr),
        .i_wbq_alloc_data(i_wbq_alloc_data), .o_wbq_credit(o_wbq_credit),
        .o_req(wbq_req), .o_req_addr(wbq_req_addr), .o_req_data(wbq_req_data),
        .i_done(wbq_done)
    );

    ccu_arbiter u_arbiter (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_ifq_req(ifq_req), .i_ifq_addr(ifq_req_addr), .o_ifq_done(ifq_done),
        .i_wbq_req(wbq_req), .i_wbq_addr(wbq_req_addr), .i_wbq_data(wbq_req_data),
        .o_wbq_done(wbq_done),
        .o_mem_en(mem_en), .o_mem_op(mem_op), .o_mem_addr(mem_addr),
        .o_mem_wdata(mem_wdata), .i_mem_done(mem_done)
    );

    ccu_mem u_mem (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_mem_en(mem_en), .i_mem_op(mem_op), .i_mem_addr(mem_addr),
        .i_mem_wdata(mem_wdata), .o_mem_done(mem_done), .o_mem_rdata(mem_rdata)
    );

endmodule

//--- sim/ccu_top_assert.sv
// **************************************************
// CCU assertion checks
// Arbiter grant timing, IFQ overflow and fill timing
// **************************************************

`timescale 1ns/1ps

module ccu_top_assert (
    input  logic    clk,
    input  logic    i_arst_n,
    input  logic    i_mem_en,
    input  logic    i_arb_idle,
    input  logic    i_alloc_en,
    input  logic    i_ifq_full,
    input  logic    i_done,
    input  logic    i_fill_en
);

    // Number of assertion failures so far
    int assert_errors = 0;

    // A memory transaction starts only from the idle state
    mem_en_in_idle: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_mem_en |-> i_arb_idle)
        else begin
            $error("o_mem_en raised while the arbiter is busy");
            assert_errors++;
        end

    // Requester never allocates into a full IFQ
    no_alloc_when_full: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_alloc_en |-> !i_ifq_full)
        else begin
            $error("IFQ allocation while every entry is valid");
            assert_errors++;
        end

    // Fill pulse comes exactly one cycle after done
    fill_after_done: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_done |=> i_fill_en)
        else begin
            $error("no fill one cycle after IFQ done");
            assert_errors++;
        end

    fill_only_after_done: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_fill_en |-> $past(i_done))
        else begin
            $error("fill without IFQ done in the previous cycle");
            assert_errors++;
        end

endmodule

// Arbiter instance only drives the grant check
bind ccu_arbiter ccu_top_assert u_arb_assert (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_mem_en(o_mem_en), .i_arb_idle(state_q == ccu_pkg::ARB_IDLE),
    .i_alloc_en(1'b0), .i_ifq_full(1'b0), .i_done(1'b0), .i_fill_en(1'b0)
);

bind ccu_ifq ccu_top_assert u_ifq_assert (
    .clk(clk), .i_arst_n(i_arst_n),
    .i_mem_en(1'b0), .i_arb_idle(1'b1),
    .i_alloc_en(i_ifq_alloc_en), .i_ifq_full(&entry_valid),
    .i_done(i_done), .i_fill_en(o_ifq_fill_en)
);

//--- sim/ccu_top_tb.sv
// **************************************************
// CCU testbench
// LFSR driven WBQ writes and IFQ reads checked
// against a shadow memory plus credit accounting
// **************************************************

`timescale 1ns/1ps
`include "ccu_settings.svh"

module ccu_top_tb;

    localparam int CLK_PERIOD     = 10;
    localparam int AW             = `CCU_ADDR_WIDTH;
    localparam int LW             = `CCU_LINE_WIDTH;
    localparam int OW             = `CCU_OFFSET_WIDTH;
    localparam int IW             = `CCU_MEM_IDX_WIDTH;
    localparam int WR_LINES       = 8;
    localparam int ORDER_READS    = 2 * `CCU_IFQ_DEPTH;
    localparam int RAND_OPS       = 48;
    localparam int NUM_OPS        = 2 * WR_LINES + ORDER_READS + RAND_OPS;
    localparam int TIMEOUT_CYCLES = NUM_OPS * (`CCU_MEM_LATENCY + 4) * 2 + 50;

    logic           clk;
    logic           i_arst_n;
    logic           i_ifq_alloc_en;
    logic [AW-1:0]  i_ifq_alloc_addr;
    logic           o_ifq_fill_en;
    logic [AW-1:0]  o_ifq_fill_addr;
    logic [LW-1:0]  o_ifq_fill_data;
    logic           o_ifq_credit;
    logic           i_wbq_alloc_en;
    logic [AW-1:0]  i_wbq_alloc_addr;
    logic [LW-1:0]  i_wbq_alloc_data;
    logic           o_wbq_credit;

    logic [15:0]        lfsr_q;
    logic [LW-1:0]      shadow_mem [`CCU_MEM_LINES];
    logic               shadow_valid [`CCU_MEM_LINES];
    int                 wr_pending [`CCU_MEM_LINES];
    int                 rd_pending [`CCU_MEM_LINES];
    logic [AW+LW-1:0]   exp_fills [$];
    logic [IW+LW-1:0]   wr_inflight [$];
    logic [AW+LW-1:0]   exp_fill;
    logic [IW+LW-1:0]   wr_done;
    logic [IW-1:0]      written_idx [WR_LINES];
    int ifq_credits, wbq_credits, ifq_allocs, wbq_allocs, ifq_returns, wbq_returns;
    int mismatch_count, error_count, i;

    ccu_top uut (
        .clk(clk), .i_arst_n(i_arst_n),
        .i_ifq_alloc_en(i_ifq_alloc_en), .i_ifq_alloc_addr(i_ifq_alloc_addr),
        .o_ifq_fill_en(o_ifq_fill_en), .o_ifq_fill_addr(o_ifq_fill_addr),
        .o_ifq_fill_data(o_ifq_fill_data), .o_ifq_credit(o_ifq_credit),
        .i_wbq_alloc_en(i_wbq_alloc_en), .i_wbq_alloc_addr(i_wbq_alloc_addr),
        .i_wbq_alloc_data(i_wbq_alloc_data), .o_wbq_credit(o_wbq_credit)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int k = 0; k < n; k++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[62:0], fb};
        end
        return v;
    endfunction

    // Random tag and offset bits around the chosen line index
    function automatic logic [AW-1:0] make_addr(input logic [IW-1:0] idx);
        logic [AW-1:0] a;
        a = AW'(take_bits(AW));
        a[OW+IW-1:OW] = idx;
        return a;
    endfunction

    // Expected fill is the line address and the shadow copy of that line
    function automatic logic [AW+LW-1:0] ref_fill(input logic [AW-1:0] addr);
        logic [AW-1:0] line_addr;
        logic [IW-1:0] idx;
        line_addr = addr & ~(AW'((1 << OW) - 1));
        idx       = addr[OW+IW-1:OW];
        return {line_addr, shadow_mem[idx]};
    endfunction

    task automatic wbq_write(input logic [IW-1:0] idx);
        logic [LW-1:0] data;
        data = take_bits(LW);
        while (wbq_credits == 0) @(negedge clk);
        i_wbq_alloc_en   = 1'b1;
        i_wbq_alloc_addr = make_addr(idx);
        i_wbq_alloc_data = data;
        wbq_credits--;
        wbq_allocs++;
        wr_pending[idx]++;
        wr_inflight.push_back({idx, data});
        @(negedge clk);
        i_wbq_alloc_en = 1'b0;
    endtask

    task automatic ifq_read(input logic [IW-1:0] idx);
        logic [AW-1:0] addr;
        addr = make_addr(idx);
        while (ifq_credits == 0) @(negedge clk);
        i_ifq_alloc_en   = 1'b1;
        i_ifq_alloc_addr = addr;
        ifq_credits--;
        ifq_allocs++;
        rd_pending[idx]++;
        exp_fills.push_back(ref_fill(addr));
        @(negedge clk);
        i_ifq_alloc_en = 1'b0;
    endtask

    task automatic wait_all_credits();
        while (ifq_credits != `CCU_IFQ_DEPTH || wbq_credits != `CCU_WBQ_DEPTH) begin
            @(negedge clk);
        end
    endtask

    // Writes avoid lines with reads in flight and reads avoid lines with writes in flight
    task automatic random_op();
        logic [IW-1:0] idx;
        logic [1:0]    gap;
        logic          is_write;
        logic          found;
        gap      = 2'(take_bits(2));
        is_write = 1'(take_bits(1));
        idx      = IW'(take_bits(IW));
        found    = 1'b0;
        repeat (gap) @(negedge clk);
        for (int k = 0; k < `CCU_MEM_LINES && !found; k++) begin
            if (is_write) begin
                found = (rd_pending[idx] == 0);
            end else begin
                found = shadow_valid[idx] && (wr_pending[idx] == 0);
            end
            if (!found) begin
                idx = idx + 1'b1;
            end
        end
        if (found && is_write) begin
            wbq_write(idx);
        end else if (found) begin
            ifq_read(idx);
        end
    endtask

    // Fill checker samples the outputs before this edge updates them
    always @(posedge clk) begin
        if (i_arst_n && o_ifq_fill_en === 1'b1) begin
            if (exp_fills.size() == 0) begin
                error_count++;
                $display("IFQ returned a fill at %0t with no read outstanding", $time);
            end else begin
                exp_fill = exp_fills.pop_front();
                if (o_ifq_fill_addr !== exp_fill[AW+LW-1:LW]) begin
                    mismatch_count++;
                    $display("mismatch at %0t: fill address %h, expected %h",
                             $time, o_ifq_fill_addr, exp_fill[AW+LW-1:LW]);
                end
                if (o_ifq_fill_data !== exp_fill[LW-1:0]) begin
                    mismatch_count++;
                    $display("mismatch at %0t: fill data %h, expected %h",
                             $time, o_ifq_fill_data, exp_fill[LW-1:0]);
                end
                rd_pending[exp_fill[LW+OW+IW-1:LW+OW]]--;
            end
        end
        if (i_arst_n && o_ifq_credit !== o_ifq_fill_en) begin
            error_count++;
            $display("IFQ credit pulse and fill pulse disagree at %0t", $time);
        end
    end

    // A returned write credit commits the line to the shadow memory
    always @(posedge clk) begin
        if (i_arst_n && o_ifq_credit === 1'b1) begin
            ifq_credits++;
            ifq_returns++;
        end
        if (i_arst_n && o_wbq_credit === 1'b1) begin
            if (wr_inflight.size() == 0) begin
                error_count++;
                $display("WBQ returned a credit at %0t with no write outstanding", $time);
            end else begin
                wr_done = wr_inflight.pop_front();
                shadow_mem[wr_done[IW+LW-1:LW]]   = wr_done[LW-1:0];
                shadow_valid[wr_done[IW+LW-1:LW]] = 1'b1;
                wr_pending[wr_done[IW+LW-1:LW]]--;
            end
            wbq_credits++;
            wbq_returns++;
        end
    end

    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        i_arst_n         = 1'b0;
        i_ifq_alloc_en   = 1'b0;
        i_ifq_alloc_addr = '0;
        i_wbq_alloc_en   = 1'b0;
        i_wbq_alloc_addr = '0;
        i_wbq_alloc_data = '0;
        lfsr_q           = 16'd23717;
        ifq_credits      = `CCU_IFQ_DEPTH;
        wbq_credits      = `CCU_WBQ_DEPTH;
        ifq_allocs       = 0;
        wbq_allocs       = 0;
        ifq_returns      = 0;
        wbq_returns      = 0;
        mismatch_count   = 0;
        error_count      = 0;
        for (i = 0; i < `CCU_MEM_LINES; i++) begin
            shadow_valid[i] = 1'b0;
            wr_pending[i]   = 0;
            rd_pending[i]   = 0;
        end
        repeat (3) @(negedge clk);
        i_arst_n = 1'b1;

        // Quiet outputs and full credits before any allocation
        repeat (4) begin
            @(negedge clk);
            if (o_ifq_fill_en !== 1'b0 || o_ifq_credit !== 1'b0 || o_wbq_credit !== 1'b0) begin
                error_count++;
                $display("Fill or credit output active at %0t before any allocation", $time);
            end
            if (ifq_credits != `CCU_IFQ_DEPTH || wbq_credits != `CCU_WBQ_DEPTH) begin
                error_count++;
                $display("Requester credits not full after reset");
            end
        end

        // Write lines and read each back once its credit has returned
        for (i = 0; i < WR_LINES; i++) begin
            written_idx[i] = IW'(take_bits(IW));
            wbq_write(written_idx[i]);
        end
        wait_all_credits();
        for (i = 0; i < WR_LINES; i++) begin
            ifq_read(written_idx[i]);
        end
        wait_all_credits();

        // Back-to-back reads that run the IFQ out of credits
        for (i = 0; i < ORDER_READS; i++) begin
            ifq_read(written_idx[i]);
        end
        wait_all_credits();

        for (i = 0; i < RAND_OPS; i++) begin
            random_op();
        end
        wait_all_credits();
        repeat (4) @(negedge clk);

        if (ifq_credits != `CCU_IFQ_DEPTH || ifq_returns != ifq_allocs) begin
            error_count++;
            $display("IFQ credits end at %0d, %0d returned for %0d allocations",
                     ifq_credits, ifq_returns, ifq_allocs);
        end
        if (wbq_credits != `CCU_WBQ_DEPTH || wbq_returns != wbq_allocs) begin
            error_count++;
            $display("WBQ credits end at %0d, %0d returned for %0d allocations",
                     wbq_credits, wbq_returns, wbq_allocs);
        end
        if (exp_fills.size() != 0) begin
            error_count++;
            $display("%0d reads never received a fill", exp_fills.size());
        end
        if (uut.u_arbiter.u_arb_assert.assert_errors != 0 ||
            uut.u_ifq.u_ifq_assert.assert_errors != 0) begin
            error_count++;
            $display("Bound assertions failed %0d times in the arbiter and %0d in the IFQ",
                     uut.u_arbiter.u_arb_assert.assert_errors,
                     uut.u_ifq.u_ifq_assert.assert_errors);
        end
        $display("errors: %0d mismatches, %0d other failures", mismatch_count, error_count);
        if (mismatch_count == 0 && error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

//--- ccu_top.f
+incdir+rtl
rtl/ccu_pkg.sv
rtl/ccu_ifq.sv
rtl/ccu_wbq.sv
rtl/ccu_arbiter.sv
rtl/ccu_mem.sv
rtl/ccu_top.sv
sim/ccu_top_assert.sv
sim/ccu_top_tb.sv
